// File: hdl/des_cfg.svh
`ifndef DES_CFG_SVH
`define DES_CFG_SVH

// Data block and key width
`define DES_BLOCK_W 64

// One Feistel half
`define DES_HALF_W 32

// C and D halves of the key after PC1
`define DES_CD_W 28

// Round subkey after PC2
`define DES_SUBKEY_W 48

// Iteration count and index width
`define DES_ROUNDS 16
`define DES_ROUND_IDX_W 4

`endif

// File: hdl/des_core.sv
`timescale 1ns/1ns
`default_nettype none

module des_core (
    input  logic                clk,
    input  logic                rst_n,
    input  des_pkg::des_req_t   req,
    input  logic                req_valid,
    output logic                req_ready,
    output des_pkg::des_block_t res,
    output logic                res_valid,
    input  logic                res_ready
);

    import des_pkg::*;

    des_ctrl_t   ctrl;
    logic        round_last;
    rot_t        rot;
    des_subkey_t subkey;

    // ------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------
    des_ctrl_fsm i_ctrl_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .round_last (round_last),
        .ctrl       (ctrl)
    );

    des_round_counter i_round_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .decrypt    (req.decrypt),
        .round_last (round_last),
        .rot        (rot)
    );

    // ------------------------------------------------------------------
    // Datapaths
    // ------------------------------------------------------------------
    des_key_schedule i_key_schedule (
        .clk    (clk),
        .key    (req.key),
        .ctrl   (ctrl),
        .rot    (rot),
        .subkey (subkey)
    );

    des_round i_round (
        .clk    (clk),
        .block  (req.block),
        .ctrl   (ctrl),
        .subkey (subkey),
        .res    (res)
    );

endmodule

`default_nettype wire

// File: hdl/des_ctrl_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module des_ctrl_fsm (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    output logic               req_ready,
    output logic               res_valid,
    input  logic               res_ready,
    input  logic               round_last,
    output des_pkg::des_ctrl_t ctrl
);

    import des_pkg::*;

    des_state_t state;
    des_state_t state_nxt;

    // ------------------------------------------------------------------
    // State register and next-state logic
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (req_valid) begin
                    state_nxt = ST_ROUND;
                end
            end
            ST_ROUND: begin
                // Last step edge moves on to the result
                if (round_last) begin
                    state_nxt = ST_DONE;
                end
            end
            ST_DONE: begin
                if (res_ready) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    // Handshake flags follow the state directly
    assign req_ready = (state == ST_IDLE);
    assign res_valid = (state == ST_DONE);

    assign ctrl = '{load: req_ready && req_valid, step: state == ST_ROUND};

    // Result held until the consumer takes it
    a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid && !res_ready |=> res_valid)
        else $error("res_valid dropped before res_ready");

    a_load_step_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctrl.load && ctrl.step))
        else $error("load and step high together");

endmodule

`default_nettype wire

// File: hdl/des_key_schedule.sv
`timescale 1ns/1ns
`default_nettype none

`include "des_cfg.svh"

module des_key_schedule (
    input  logic                 clk,
    input  des_pkg::des_block_t  key,
    input  des_pkg::des_ctrl_t   ctrl,
    input  des_pkg::rot_t        rot,
    output des_pkg::des_subkey_t subkey
);

    import des_pkg::*;

    // Standard 1-based bit numbers, bit 1 is the MSB
    localparam int PC1_TBL [56] = '{
        57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
        10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
        14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
    };

    localparam int PC2_TBL [48] = '{
        14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10,
        23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
        41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
        44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
    };

    logic [2*`DES_CD_W-1:0] pc1_out;
    logic [2*`DES_CD_W-1:0] cd_rot;
    des_cd_t                c_q;
    des_cd_t                d_q;

    function automatic des_cd_t rotate_half(des_cd_t v, rot_t r);
        des_cd_t o;
        case (r)
            ROT_L1:  o = {v[`DES_CD_W-2:0], v[`DES_CD_W-1]};
            ROT_L2:  o = {v[`DES_CD_W-3:0], v[`DES_CD_W-1 -: 2]};
            ROT_R1:  o = {v[0], v[`DES_CD_W-1:1]};
            ROT_R2:  o = {v[1:0], v[`DES_CD_W-1:2]};
            default: o = v;
        endcase
        return o;
    endfunction

    // PC1 drops the parity bits of the key
    always_comb begin
        for (int i = 0; i < 2 * `DES_CD_W; i++) begin
            pc1_out[2*`DES_CD_W-1-i] = key[`DES_BLOCK_W - PC1_TBL[i]];
        end
    end

    assign cd_rot = {rotate_half(c_q, rot), rotate_half(d_q, rot)};

    always_comb begin
        for (int i = 0; i < `DES_SUBKEY_W; i++) begin
            subkey[`DES_SUBKEY_W-1-i] = cd_rot[2*`DES_CD_W - PC2_TBL[i]];
        end
    end

    // Halves carry the rotation forward into the next round
    always_ff @(posedge clk) begin
        if (ctrl.load) begin
            c_q <= pc1_out[2*`DES_CD_W-1:`DES_CD_W];
            d_q <= pc1_out[`DES_CD_W-1:0];
        end else if (ctrl.step) begin
            c_q <= cd_rot[2*`DES_CD_W-1:`DES_CD_W];
            d_q <= cd_rot[`DES_CD_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: hdl/des_pkg.sv
`default_nettype none

`include "des_cfg.svh"

package des_pkg;

    typedef logic [`DES_BLOCK_W-1:0]     des_block_t;
    typedef logic [`DES_HALF_W-1:0]      des_half_t;
    typedef logic [`DES_CD_W-1:0]        des_cd_t;
    typedef logic [`DES_SUBKEY_W-1:0]    des_subkey_t;
    typedef logic [`DES_ROUND_IDX_W-1:0] round_idx_t;

    // One request: data, key and direction
    typedef struct packed {
        des_block_t block;
        des_block_t key;
        logic       decrypt;
    } des_req_t;

    // Strobes from the FSM to counter and datapaths
    typedef struct packed {
        logic load;
        logic step;
    } des_ctrl_t;

    // Rotation applied to C and D in the current round
    typedef enum logic [2:0] {
        ROT_NONE,
        ROT_L1,
        ROT_L2,
        ROT_R1,
        ROT_R2
    } rot_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ROUND,
        ST_DONE
    } des_state_t;

    // ------------------------------------------------------------------
    // S-boxes S1..S8, entry index is {outer row bits, inner column bits}
    // ------------------------------------------------------------------
    localparam logic [3:0] DES_SBOX [8][64] = '{
        '{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
           0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
           4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
          15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13},
        '{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
           3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
           0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
          13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9},
        '{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
          13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
          13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
           1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12},
        '{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
          13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
          10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
           3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14},
        '{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
          14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
           4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
          11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3},
        '{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
          10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
           9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
           4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13},
        '{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
          13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
           1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
           6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12},
        '{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
           1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
           7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
           2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}
    };

endpackage

`default_nettype wire

// File: hdl/des_round.sv
`timescale 1ns/1ns
`default_nettype none

`include "des_cfg.svh"

module des_round (
    input  logic                 clk,
    input  des_pkg::des_block_t  block,
    input  des_pkg::des_ctrl_t   ctrl,
    input  des_pkg::des_subkey_t subkey,
    output des_pkg::des_block_t  res
);

    import des_pkg::*;

    // ------------------------------------------------------------------
    // Permutation tables, standard 1-based numbering from the MSB
    // ------------------------------------------------------------------
    localparam int IP_TBL [64] = '{
        58, 50, 42, 34, 26, 18, 10,  2, 60, 52, 44, 36, 28, 20, 12,  4,
        62, 54, 46, 38, 30, 22, 14,  6, 64, 56, 48, 40, 32, 24, 16,  8,
        57, 49, 41, 33, 25, 17,  9,  1, 59, 51, 43, 35, 27, 19, 11,  3,
        61, 53, 45, 37, 29, 21, 13,  5, 63, 55, 47, 39, 31, 23, 15,  7
    };

    localparam int FP_TBL [64] = '{
        40,  8, 48, 16, 56, 24, 64, 32, 39,  7, 47, 15, 55, 23, 63, 31,
        38,  6, 46, 14, 54, 22, 62, 30, 37,  5, 45, 13, 53, 21, 61, 29,
        36,  4, 44, 12, 52, 20, 60, 28, 35,  3, 43, 11, 51, 19, 59, 27,
        34,  2, 42, 10, 50, 18, 58, 26, 33,  1, 41,  9, 49, 17, 57, 25
    };

    // Expansion, 32 to 48 bits
    localparam int E_TBL [48] = '{
        32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
         8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
    };

    localparam int P_TBL [32] = '{
        16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
    };

    des_block_t  ip_out;
    des_block_t  fp_in;
    des_half_t   l_q;
    des_half_t   r_q;
    des_subkey_t e_out;
    des_subkey_t mix;
    des_half_t   sbox_out;
    des_half_t   f_out;

    always_comb begin
        for (int i = 0; i < `DES_BLOCK_W; i++) begin
            ip_out[`DES_BLOCK_W-1-i] = block[`DES_BLOCK_W - IP_TBL[i]];
        end
    end

    // ------------------------------------------------------------------
    // f function
    // ------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < `DES_SUBKEY_W; i++) begin
            e_out[`DES_SUBKEY_W-1-i] = r_q[`DES_HALF_W - E_TBL[i]];
        end
    end

    assign mix = e_out ^ subkey;

    // Six bits in, four out; S1 takes the top six bits
    always_comb begin
        logic [5:0] six;
        for (int s = 0; s < 8; s++) begin
            six = mix[`DES_SUBKEY_W-1-6*s -: 6];
            sbox_out[`DES_HALF_W-1-4*s -: 4] = DES_SBOX[s][{six[5], six[0], six[4:1]}];
        end
    end

    always_comb begin
        for (int i = 0; i < `DES_HALF_W; i++) begin
            f_out[`DES_HALF_W-1-i] = sbox_out[`DES_HALF_W - P_TBL[i]];
        end
    end

    // One Feistel round per step
    always_ff @(posedge clk) begin
        if (ctrl.load) begin
            l_q <= ip_out[`DES_BLOCK_W-1:`DES_HALF_W];
            r_q <= ip_out[`DES_HALF_W-1:0];
        end else if (ctrl.step) begin
            l_q <= r_q;
            r_q <= l_q ^ f_out;
        end
    end

    // Halves swapped back before FP
    assign fp_in = {r_q, l_q};

    always_comb begin
        for (int i = 0; i < `DES_BLOCK_W; i++) begin
            res[`DES_BLOCK_W-1-i] = fp_in[`DES_BLOCK_W - FP_TBL[i]];
        end
    end

endmodule

`default_nettype wire

// File: hdl/des_round_counter.sv
`timescale 1ns/1ns
`default_nettype none

`include "des_cfg.svh"

module des_round_counter (
    input  logic               clk,
    input  logic               rst_n,
    input  des_pkg::des_ctrl_t ctrl,
    input  logic               decrypt,
    output logic               round_last,
    output des_pkg::rot_t      rot
);

    import des_pkg::*;

    round_idx_t idx_q;
    logic       decrypt_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_q     <= '0;
            decrypt_q <= 1'b0;
        end else if (ctrl.load) begin
            idx_q     <= '0;
            decrypt_q <= decrypt;
        end else if (ctrl.step) begin
            idx_q <= round_idx_t'(idx_q + 1'b1);
        end
    end

    assign round_last = (idx_q == round_idx_t'(`DES_ROUNDS - 1));

    // Single shifts fall on rounds 1, 2, 9 and 16 of the standard schedule
    always_comb begin
        if (!decrypt_q) begin
            rot = (idx_q == 4'd0 || idx_q == 4'd1 || idx_q == 4'd8 || idx_q == 4'd15)
                ? ROT_L1 : ROT_L2;
        end else if (idx_q == 4'd0) begin
            // K16 comes straight from the PC1 halves
            rot = ROT_NONE;
        end else begin
            rot = (idx_q == 4'd1 || idx_q == 4'd8 || idx_q == 4'd15) ? ROT_R1 : ROT_R2;
        end
    end

    a_idx_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !ctrl.step && !ctrl.load |=> $stable(idx_q))
        else $error("round index moved without step");

endmodule

`default_nettype wire

// File: testbench/des_vectors.svh
`ifndef DES_VECTORS_SVH
`define DES_VECTORS_SVH

// Columns: plaintext, key, ciphertext, one entry per vector
localparam int KAT_COUNT = 2;

localparam des_block_t KAT_PT [KAT_COUNT] = '{
    64'h0123_4567_89AB_CDEF,
    64'h8787_8787_8787_8787
};

localparam des_block_t KAT_KEY [KAT_COUNT] = '{
    64'h1334_5779_9BBC_DFF1,
    64'h0E32_9232_EA6D_0D73
};

localparam des_block_t KAT_CT [KAT_COUNT] = '{
    64'h85E8_1354_0F0A_B405,
    64'h0000_0000_0000_0000
};

// All sixteen subkeys of this key are equal
localparam des_block_t WEAK_KEY = 64'h0101_0101_0101_0101;

`endif

// File: testbench/des_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module des_core_tb;

    import des_pkg::*;

    `include "des_vectors.svh"

    localparam int WAIT_LIMIT  = 100;
    localparam int DRIVE_DELAY = 5;

    logic       clk;
    logic       rst_n;
    des_req_t   req;
    logic       req_valid;
    logic       req_ready;
    des_block_t res;
    logic       res_valid;
    logic       res_ready;

    // Expected result and bookkeeping seen by the assertions
    string      test_name;
    des_block_t exp_res;
    logic       check_en;
    logic       accepted_any;
    int         error_count;
    int         test_errors;
    int         tests_passed;
    int         tests_failed;
    integer     seed;

    des_core i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accepted_any <= 1'b0;
        end else if (req_valid && req_ready) begin
            accepted_any <= 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    a_reset_state: assert property (@(posedge clk) disable iff (!rst_n)
        !accepted_any |-> req_ready && !res_valid)
        else begin
            error_count++;
            $display("Error in %s: core not idle and ready after reset", test_name);
        end

    // Sixteen round edges, then the result
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && req_ready |=> (!res_valid && !req_ready) [*16] ##1 res_valid)
        else begin
            error_count++;
            $display("Error in %s: res_valid not high 16 cycles after accept", test_name);
        end

    a_result_value: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid && res_ready && check_en |-> res == exp_res)
        else begin
            error_count++;
            $display("Fail %s: expected %h actual %h", test_name, $sampled(exp_res),
                     $sampled(res));
        end

    a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid && !res_ready |=> res_valid && !req_ready && $stable(res))
        else begin
            error_count++;
            $display("Error in %s: result changed while waiting for res_ready", test_name);
        end

    a_ready_after_take: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid && res_ready |=> req_ready)
        else begin
            error_count++;
            $display("Error in %s: req_ready low one cycle after result taken", test_name);
        end

    a_result_known: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> !$isunknown(res))
        else begin
            error_count++;
            $display("Error in %s: result has unknown bits", test_name);
        end

    // ------------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------------
    task automatic abort_wait(input string what);
        $display("Timeout in %s while waiting for %s", test_name, what);
        $display("FAIL: see errors above");
        $finish;
    endtask

    task automatic send_request(input des_block_t block, input des_block_t key,
                                input logic decrypt);
        int n;
        req.block   = block;
        req.key     = key;
        req.decrypt = decrypt;
        req_valid   = 1'b1;
        n = 0;
        while (!req_ready) begin
            if (n == WAIT_LIMIT) begin
                abort_wait("req_ready");
            end
            n++;
            @(posedge clk);
            #DRIVE_DELAY;
        end
        // Taken on this edge
        @(posedge clk);
        #DRIVE_DELAY;
        req_valid = 1'b0;
    endtask

    task automatic collect_result(input des_block_t expected, input logic check,
                                  input int hold_cycles, output des_block_t got);
        int n;
        n = 0;
        while (!res_valid) begin
            if (n == WAIT_LIMIT) begin
                abort_wait("res_valid");
            end
            n++;
            @(posedge clk);
            #DRIVE_DELAY;
        end
        repeat (hold_cycles) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        got       = res;
        exp_res   = expected;
        check_en  = check;
        res_ready = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        res_ready = 1'b0;
        check_en  = 1'b0;
    endtask

    task automatic process_block(input des_block_t block, input des_block_t key,
                                 input logic decrypt, input des_block_t expected,
                                 input logic check, output des_block_t got);
        send_request(block, key, decrypt);
        collect_result(expected, check, 0, got);
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = error_count;
    endtask

    task automatic end_test();
        @(posedge clk);
        #DRIVE_DELAY;
        if (error_count == test_errors) begin
            tests_passed++;
            $display("Test %-14s ok", test_name);
        end else begin
            tests_failed++;
            $display("Test %-14s failed, %0d errors", test_name, error_count - test_errors);
        end
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        des_block_t got;
        des_block_t ct;
        des_block_t blk;
        des_block_t key;
        int         hold;
        seed         = 32'h0cdce8f4;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_name    = "reset";
        exp_res      = '0;
        check_en     = 1'b0;
        rst_n        = 1'b0;
        req          = '0;
        req_valid    = 1'b0;
        res_ready    = 1'b0;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        begin_test("reset_state");
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        end_test();

        begin_test("kat_encrypt");
        for (int i = 0; i < KAT_COUNT; i++) begin
            process_block(KAT_PT[i], KAT_KEY[i], 1'b0, KAT_CT[i], 1'b1, got);
        end
        end_test();

        begin_test("kat_decrypt");
        for (int i = 0; i < KAT_COUNT; i++) begin
            process_block(KAT_CT[i], KAT_KEY[i], 1'b1, KAT_PT[i], 1'b1, got);
        end
        end_test();

        begin_test("round_trip");
        for (int i = 0; i < 20; i++) begin
            blk = {$random(seed), $random(seed)};
            key = {$random(seed), $random(seed)};
            process_block(blk, key, 1'b0, '0, 1'b0, ct);
            process_block(ct, key, 1'b1, blk, 1'b1, got);
        end
        end_test();

        // Encrypting twice under a weak key gives the plaintext back
        begin_test("weak_key");
        blk = {$random(seed), $random(seed)};
        process_block(blk, WEAK_KEY, 1'b0, '0, 1'b0, ct);
        process_block(ct, WEAK_KEY, 1'b0, blk, 1'b1, got);
        end_test();

        begin_test("latency");
        process_block(KAT_PT[0], KAT_KEY[0], 1'b0, KAT_CT[0], 1'b1, got);
        end_test();

        begin_test("back_pressure");
        for (int i = 0; i < 4; i++) begin
            hold = $unsigned($random(seed)) % 11;
            send_request(KAT_PT[i % 2], KAT_KEY[i % 2], 1'b0);
            collect_result(KAT_CT[i % 2], 1'b1, hold, got);
            // Next request right behind the take edge
            send_request(KAT_CT[i % 2], KAT_KEY[i % 2], 1'b1);
            collect_result(KAT_PT[i % 2], 1'b1, 0, got);
        end
        end_test();

        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hdl
+incdir+testbench
hdl/des_pkg.sv
hdl/des_ctrl_fsm.sv
hdl/des_round_counter.sv
hdl/des_key_schedule.sv
hdl/des_round.sv
hdl/des_core.sv
testbench/des_core_tb.sv
